// File: cell_vote.sv
`include "reorder_consts.svh"

module cell_vote import reorder_pkg::*; (
    input  cell_vec_t         i_valid,
    input  tag_id_t           i_id [`CELL_MAX],
    input  qos_t              i_qos [`CELL_MAX],
    input  cell_vec_t         i_eligible,
    input  tag_id_t           i_load_id,
    input  logic              i_pop,
    input  tag_id_t           i_pop_id,
    output cell_vec_t         o_load_sel,
    output logic [`SEQ_W-1:0] o_load_seq,
    output logic [`SEQ_W-1:0] o_cells_used,
    output cell_vec_t         o_win_sel,
    output logic              o_win_valid,
    output tag_id_t           o_win_id,
    output qos_t              o_win_qos
);

    logic              free_found;
    logic [`SEQ_W-1:0] same_cnt;

    // first free cell, counts
    always_comb begin
        o_load_sel   = '0;
        free_found   = 1'b0;
        o_cells_used = '0;
        same_cnt     = '0;
        for (int i = 0; i < `CELL_MAX; i++) begin
            if (!i_valid[i] && !free_found) begin
                o_load_sel[i] = 1'b1;
                free_found    = 1'b1;
            end
            o_cells_used = o_cells_used + {{(`SEQ_W-1){1'b0}}, i_valid[i]};
            if (i_valid[i] && (i_id[i] == i_load_id))
                same_cnt = same_cnt + 1'b1;
        end
    end

    // the cell popped this cycle is no longer ahead of the new flit
    assign o_load_seq = same_cnt - {{(`SEQ_W-1){1'b0}}, (i_pop && (i_pop_id == i_load_id))};

    // strict compare keeps the lowest index on a qos tie
    always_comb begin
        o_win_sel   = '0;
        o_win_valid = 1'b0;
        o_win_id    = '0;
        o_win_qos   = '0;
        for (int i = 0; i < `CELL_MAX; i++) begin
            if (i_eligible[i] && (!o_win_valid || (i_qos[i] > o_win_qos))) begin
                o_win_sel     = '0;
                o_win_sel[i]  = 1'b1;
                o_win_valid   = 1'b1;
                o_win_id      = i_id[i];
                o_win_qos     = i_qos[i];
            end
        end
    end

    always_comb begin
        if (!$isunknown(i_eligible))
            assert ($onehot0(o_win_sel))
                else $error("vote: more than one winner");
    end

endmodule

// File: egress_stage.sv
module egress_stage import reorder_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      i_win_valid,
    input  cell_vec_t i_win_sel,
    input  tag_id_t   i_win_id,
    input  qos_t      i_win_qos,
    input  payload_t  i_win_payload,
    input  logic      i_ready_c,
    output logic      o_valid_c,
    output tag_id_t   o_id_c,
    output qos_t      o_qos_c,
    output payload_t  o_payload_c,
    output logic      o_pop,
    output cell_vec_t o_pop_sel,
    output tag_id_t   o_pop_id
);

    egress_state_e state;
    egress_state_e state_next;
    logic          drain;

    assign drain     = o_valid_c & i_ready_c;
    assign o_valid_c = (state == EG_HOLD);

    // refill when empty or when the current flit leaves this cycle
    assign o_pop     = i_win_valid & ((state == EG_EMPTY) | drain);
    assign o_pop_sel = i_win_sel;
    assign o_pop_id  = i_win_id;

    always_comb begin
        state_next = state;
        case (state)
            EG_EMPTY: if (o_pop) state_next = EG_HOLD;
            EG_HOLD:  if (drain && !o_pop) state_next = EG_EMPTY;
            default:  state_next = EG_EMPTY;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= EG_EMPTY;
        else
            state <= state_next;
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            o_id_c      <= i_win_id;
            o_qos_c     <= i_win_qos;
            o_payload_c <= i_win_payload;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        o_valid_c && !i_ready_c |=> o_valid_c && $stable({o_id_c, o_qos_c, o_payload_c}))
        else $error("egress: port c changed under back-pressure");

endmodule

// File: intake_arbiter.sv
`include "reorder_consts.svh"

module intake_arbiter import reorder_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_valid_a,
    input  logic [`PORT_ID_W-1:0] i_id_a,
    input  qos_t                  i_qos_a,
    input  payload_t              i_payload_a,
    output logic                  o_ready_a,
    input  logic                  i_valid_b,
    input  logic [`PORT_ID_W-1:0] i_id_b,
    input  qos_t                  i_qos_b,
    input  payload_t              i_payload_b,
    output logic                  o_ready_b,
    input  logic [`SEQ_W-1:0]     i_cells_used,
    output logic                  o_load_en,
    output tag_id_t               o_load_id,
    output qos_t                  o_load_qos,
    output payload_t              o_load_payload
);

    port_sel_e       port_sel;
    port_sel_e       sel_next;
    logic            accept;
    logic [`SEQ_W:0] occ_next;
    logic            space_next;

    assign accept = (i_valid_a & o_ready_a) | (i_valid_b & o_ready_b);

    // pops are ignored here, so space is seen one cycle late at worst
    assign occ_next = {1'b0, i_cells_used} + {{`SEQ_W{1'b0}}, o_load_en}
                    + {{`SEQ_W{1'b0}}, accept};
    assign space_next = occ_next < `CELL_MAX;

    always_comb begin
        if (i_valid_a && i_valid_b)
            sel_next = (port_sel == PORT_A) ? PORT_B : PORT_A;   // take turns
        else if (i_valid_b)
            sel_next = PORT_B;
        else
            sel_next = PORT_A;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            port_sel  <= PORT_A;
            o_ready_a <= 1'b0;
            o_ready_b <= 1'b0;
            o_load_en <= 1'b0;
        end else begin
            port_sel  <= sel_next;
            o_ready_a <= space_next && (sel_next == PORT_A);
            o_ready_b <= space_next && (sel_next == PORT_B);
            o_load_en <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_load_id      <= o_ready_b ? {1'b1, i_id_b} : {1'b0, i_id_a};
            o_load_qos     <= o_ready_b ? i_qos_b : i_qos_a;
            o_load_payload <= o_ready_b ? i_payload_b : i_payload_a;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0({o_ready_a, o_ready_b}))
        else $error("intake: ready on both ports");

endmodule

// File: order_cell.sv
`include "reorder_consts.svh"

module order_cell import reorder_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_load_en,
    input  logic              i_load_sel,
    input  tag_id_t           i_load_id,
    input  qos_t              i_load_qos,
    input  logic [`SEQ_W-1:0] i_load_seq,
    input  logic              i_pop,
    input  logic              i_pop_sel,
    input  tag_id_t           i_pop_id,
    output logic              o_valid,
    output tag_id_t           o_id,
    output qos_t              o_qos,
    output logic              o_eligible,
    output logic [`SEQ_W-1:0] o_seq
);

    logic load_hit;
    logic pop_hit;
    logic advance;

    assign load_hit = i_load_en & i_load_sel;
    assign pop_hit  = i_pop & i_pop_sel;

    // an older flit of this id just left
    assign advance = i_pop & ~i_pop_sel & o_valid & (i_pop_id == o_id) & (|o_seq);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            o_valid <= 1'b0;
        else if (load_hit)
            o_valid <= 1'b1;
        else if (pop_hit)
            o_valid <= 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            o_seq <= '0;
        else if (load_hit)
            o_seq <= i_load_seq;
        else if (advance)
            o_seq <= o_seq - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (load_hit) begin
            o_id  <= i_load_id;
            o_qos <= i_load_qos;
        end
    end

    assign o_eligible = o_valid & (o_seq == '0);   // head of its id queue

    assert property (@(posedge clk) disable iff (!rst_n) load_hit |-> !o_valid)
        else $error("cell: load into occupied cell");

endmodule

// File: payload_store.sv
`include "reorder_consts.svh"

module payload_store import reorder_pkg::*; (
    input  logic      clk,
    input  logic      i_write_en,
    input  cell_vec_t i_write_sel,
    input  payload_t  i_payload,
    input  cell_vec_t i_read_sel,
    output payload_t  o_payload
);

    payload_t mem [`CELL_MAX];

    always_ff @(posedge clk) begin
        for (int i = 0; i < `CELL_MAX; i++) begin
            if (i_write_en && i_write_sel[i])
                mem[i] <= i_payload;
        end
    end

    // one-hot select, so an or-tree is enough
    always_comb begin
        o_payload = '0;
        for (int i = 0; i < `CELL_MAX; i++)
            o_payload = o_payload | ({`PAYLOAD_W{i_read_sel[i]}} & mem[i]);
    end

endmodule

// File: reorder_buffer.sv
`include "reorder_consts.svh"

module reorder_buffer import reorder_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_valid_a,
    input  logic [`PORT_ID_W-1:0] i_id_a,
    input  qos_t                  i_qos_a,
    input  payload_t              i_payload_a,
    output logic                  o_ready_a,
    input  logic                  i_valid_b,
    input  logic [`PORT_ID_W-1:0] i_id_b,
    input  qos_t                  i_qos_b,
    input  payload_t              i_payload_b,
    output logic                  o_ready_b,
    output logic                  o_valid_c,
    output tag_id_t               o_id_c,
    output qos_t                  o_qos_c,
    output payload_t              o_payload_c,
    input  logic                  i_ready_c
);

    logic              load_en;
    tag_id_t           load_id;
    qos_t              load_qos;
    payload_t          load_payload;
    cell_vec_t         load_sel;
    logic [`SEQ_W-1:0] load_seq;
    logic [`SEQ_W-1:0] cells_used;

    cell_vec_t         cell_valid;
    cell_vec_t         cell_eligible;
    tag_id_t           cell_id [`CELL_MAX];
    qos_t              cell_qos [`CELL_MAX];

    cell_vec_t         win_sel;
    logic              win_valid;
    tag_id_t           win_id;
    qos_t              win_qos;
    payload_t          win_payload;

    logic              pop;
    cell_vec_t         pop_sel;
    tag_id_t           pop_id;

    intake_arbiter intake_arbiter_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_valid_a      (i_valid_a),
        .i_id_a         (i_id_a),
        .i_qos_a        (i_qos_a),
        .i_payload_a    (i_payload_a),
        .o_ready_a      (o_ready_a),
        .i_valid_b      (i_valid_b),
        .i_id_b         (i_id_b),
        .i_qos_b        (i_qos_b),
        .i_payload_b    (i_payload_b),
        .o_ready_b      (o_ready_b),
        .i_cells_used   (cells_used),
        .o_load_en      (load_en),
        .o_load_id      (load_id),
        .o_load_qos     (load_qos),
        .o_load_payload (load_payload)
    );

    for (genvar c = 0; c < `CELL_MAX; c++) begin : g_cell
        order_cell order_cell_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .i_load_en  (load_en),
            .i_load_sel (load_sel[c]),
            .i_load_id  (load_id),
            .i_load_qos (load_qos),
            .i_load_seq (load_seq),
            .i_pop      (pop),
            .i_pop_sel  (pop_sel[c]),
            .i_pop_id   (pop_id),
            .o_valid    (cell_valid[c]),
            .o_id       (cell_id[c]),
            .o_qos      (cell_qos[c]),
            .o_eligible (cell_eligible[c]),
            .o_seq      ()
        );
    end

    cell_vote cell_vote_i (
        .i_valid      (cell_valid),
        .i_id         (cell_id),
        .i_qos        (cell_qos),
        .i_eligible   (cell_eligible),
        .i_load_id    (load_id),
        .i_pop        (pop),
        .i_pop_id     (pop_id),
        .o_load_sel   (load_sel),
        .o_load_seq   (load_seq),
        .o_cells_used (cells_used),
        .o_win_sel    (win_sel),
        .o_win_valid  (win_valid),
        .o_win_id     (win_id),
        .o_win_qos    (win_qos)
    );

    payload_store payload_store_i (
        .clk         (clk),
        .i_write_en  (load_en),
        .i_write_sel (load_sel),
        .i_payload   (load_payload),
        .i_read_sel  (win_sel),
        .o_payload   (win_payload)
    );

    egress_stage egress_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_win_valid   (win_valid),
        .i_win_sel     (win_sel),
        .i_win_id      (win_id),
        .i_win_qos     (win_qos),
        .i_win_payload (win_payload),
        .i_ready_c     (i_ready_c),
        .o_valid_c     (o_valid_c),
        .o_id_c        (o_id_c),
        .o_qos_c       (o_qos_c),
        .o_payload_c   (o_payload_c),
        .o_pop         (pop),
        .o_pop_sel     (pop_sel),
        .o_pop_id      (pop_id)
    );

endmodule

// File: reorder_consts.svh
`ifndef REORDER_CONSTS_SVH
`define REORDER_CONSTS_SVH

// buffer depth
`define CELL_MAX   24

// flit fields
`define PAYLOAD_W  128
`define PORT_ID_W  5
`define ID_W       6    // port bit + port id
`define QOS_W      2

// position in a same-id queue, also used for cell counts
`define SEQ_W      5

`endif

// File: reorder_pkg.sv
`include "reorder_consts.svh"

package reorder_pkg;

    typedef logic [`ID_W-1:0]      tag_id_t;
    typedef logic [`QOS_W-1:0]     qos_t;
    typedef logic [`PAYLOAD_W-1:0] payload_t;
    typedef logic [`CELL_MAX-1:0]  cell_vec_t;   // one bit per cell

    typedef enum logic {
        PORT_A,
        PORT_B
    } port_sel_e;

    typedef enum logic {
        EG_EMPTY,
        EG_HOLD
    } egress_state_e;

endpackage

// File: run_sim.sh
#!/bin/sh
# compile with verilator and run; a $fatal gives a failing exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_reorder_buffer -f src.f
./obj_dir/Vtb_reorder_buffer

// File: src.f
+incdir+.
reorder_pkg.sv
intake_arbiter.sv
order_cell.sv
cell_vote.sv
payload_store.sv
egress_stage.sv
reorder_buffer.sv
tb_reorder_buffer.sv

// File: tb_reorder_buffer.sv
`include "reorder_consts.svh"

module tb_reorder_buffer import reorder_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst_n;
    logic        valid_in [2];
    logic [`PORT_ID_W-1:0] id_in [2];
    qos_t        qos_in [2];
    payload_t    pay_in [2];
    logic        sent [2];      // transfer at the coming rising edge
    logic        ready_c;
    logic        o_ready_a;
    logic        o_ready_b;
    logic        o_valid_c;
    tag_id_t     o_id_c;
    qos_t        o_qos_c;
    payload_t    o_payload_c;

    logic [15:0] lfsr = 16'd31500;
    logic [31:0] serial = 32'd0;
    int          to_send;
    logic        distinct_ids;
    string       phase;

    // flits accepted but not yet seen on port C, oldest first
    tag_id_t     exp_id [$];
    qos_t        exp_qos [$];
    payload_t    exp_pay [$];

    // fill set in acceptance order, which is also cell order
    logic        fill_on;
    int          fill_n;
    int          fill_acc;
    logic [31:0] fill_ser [`CELL_MAX];
    qos_t        fill_qos [`CELL_MAX];
    logic        fill_out [`CELL_MAX];
    logic        alt_on;
    logic        alt_seen;
    logic        last_port;

    reorder_buffer reorder_buffer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_valid_a   (valid_in[0]),
        .i_id_a      (id_in[0]),
        .i_qos_a     (qos_in[0]),
        .i_payload_a (pay_in[0]),
        .o_ready_a   (o_ready_a),
        .i_valid_b   (valid_in[1]),
        .i_id_b      (id_in[1]),
        .i_qos_b     (qos_in[1]),
        .i_payload_b (pay_in[1]),
        .o_ready_b   (o_ready_b),
        .o_valid_c   (o_valid_c),
        .o_id_c      (o_id_c),
        .o_qos_c     (o_qos_c),
        .o_payload_c (o_payload_c),
        .i_ready_c   (ready_c)
    );

    always #2 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // oldest pending flit with this tagged id
    function automatic int find_expected(input tag_id_t id);
        for (int k = 0; k < exp_id.size(); k++) begin
            if (exp_id[k] == id)
                return k;
        end
        return -1;
    endfunction

    // highest qos left in the fill set, earliest accepted on a tie
    function automatic int next_priority();
        int best;
        best = -1;
        for (int k = 0; k < fill_n; k++) begin
            if (!fill_out[k] && (best < 0 || fill_qos[k] > fill_qos[best]))
                best = k;
        end
        return best;
    endfunction

    task automatic die(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic fail_value(input string what, input payload_t expv, input payload_t actv);
        die($sformatf("[FAIL] %s %s: expected %0h actual %0h", phase, what, expv, actv));
    endtask

    task automatic make_flit(input int p);
        logic [31:0] r;
        r = take_bits(2);
        id_in[p] = distinct_ids ? serial[4:0] : {3'b000, r[1:0]};
        r = take_bits(2);
        qos_in[p] = r[1:0];
        pay_in[p] = {take_bits(32), take_bits(32), take_bits(32), serial};  // serial in low word
        valid_in[p] = 1'b1;
        serial = serial + 32'd1;
        to_send = to_send - 1;
    endtask

    task automatic record(input int p);
        logic pbit;
        pbit = (p == 1);
        exp_id.push_back({pbit, id_in[p]});
        exp_qos.push_back(qos_in[p]);
        exp_pay.push_back(pay_in[p]);
        if (alt_on) begin
            if (alt_seen)
                assert (pbit != last_port)
                    else fail_value("port alternation", 128'(!last_port), 128'(pbit));
            alt_seen = 1'b1;
            last_port = pbit;
        end
        if (fill_on) begin
            if (fill_n < `CELL_MAX) begin
                fill_ser[fill_n] = pay_in[p][31:0];
                fill_qos[fill_n] = qos_in[p];
                fill_out[fill_n] = 1'b0;
                fill_n++;
            end
            fill_acc++;
        end
    endtask

    // called right after a falling edge
    task automatic step(input logic want_a, input logic want_b, input logic rdy_c);
        logic want [2];
        logic rdy;
        want[0] = want_a;
        want[1] = want_b;
        for (int p = 0; p < 2; p++) begin
            if (sent[p]) begin
                valid_in[p] = 1'b0;
                sent[p] = 1'b0;
            end
            if (!valid_in[p] && want[p] && to_send > 0)
                make_flit(p);
        end
        ready_c = rdy_c;
        for (int p = 0; p < 2; p++) begin
            rdy = (p == 0) ? o_ready_a : o_ready_b;
            if (valid_in[p] && rdy) begin
                sent[p] = 1'b1;
                record(p);
            end
        end
    endtask

    task automatic check_output();
        int          idx;
        int          k;
        int          best;
        logic [31:0] ser;
        idx = find_expected(o_id_c);
        assert (idx >= 0)
            else die($sformatf("port C sent id %0h with no such flit pending", o_id_c));
        assert (o_qos_c == exp_qos[idx])
            else fail_value("qos", 128'(exp_qos[idx]), 128'(o_qos_c));
        assert (o_payload_c == exp_pay[idx])
            else fail_value("payload", exp_pay[idx], o_payload_c);
        ser = o_payload_c[31:0];
        if (fill_on) begin
            k = -1;
            for (int j = 0; j < fill_n; j++) begin
                if (fill_ser[j] == ser)
                    k = j;
            end
            if (k >= 0) begin
                best = next_priority();
                assert (k == best)
                    else fail_value("priority order", 128'(fill_ser[best]), 128'(ser));
                fill_out[k] = 1'b1;
            end
        end
        exp_id.delete(idx);
        exp_qos.delete(idx);
        exp_pay.delete(idx);
    endtask

    // port C fields are stable here until the next rising edge
    always begin
        @(negedge clk);
        #1;
        if (rst_n && o_valid_c && ready_c)
            check_output();
    end

    initial begin
        logic [31:0] r;
        int          guard;
        clk = 1'b0;
        rst_n = 1'b0;
        ready_c = 1'b0;
        for (int p = 0; p < 2; p++) begin
            valid_in[p] = 1'b0;
            id_in[p] = '0;
            qos_in[p] = '0;
            pay_in[p] = '0;
            sent[p] = 1'b0;
        end
        to_send = 0;
        distinct_ids = 1'b0;
        fill_on = 1'b0;
        fill_n = 0;
        fill_acc = 0;
        alt_on = 1'b0;
        alt_seen = 1'b0;
        last_port = 1'b0;

        phase = "reset";
        repeat (8) begin
            @(negedge clk);
            assert (!o_ready_a && !o_ready_b && !o_valid_c)
                else die("ready or valid high during reset");
        end
        rst_n = 1'b1;
        #1;
        assert (!o_ready_a && !o_ready_b && !o_valid_c)
            else die("ready or valid high in the first cycle after reset");

        phase = "random";
        to_send = 400;
        guard = 0;
        while (to_send > 0 || valid_in[0] || valid_in[1] || exp_id.size() > 0 || o_valid_c) begin
            @(negedge clk);
            r = take_bits(3);
            step(r[0], r[1], r[2]);
            guard++;
            assert (guard < 20000) else die("timeout while running random traffic");
        end

        // one flit parks in the output register so the cells fill from cell 0
        phase = "fill";
        distinct_ids = 1'b1;
        to_send = 1;
        guard = 0;
        while (!o_valid_c) begin
            @(negedge clk);
            step(1'b1, 1'b0, 1'b0);
            guard++;
            assert (guard < 100) else die("timeout waiting for the first flit on port C");
        end
        fill_on = 1'b1;
        alt_on = 1'b1;
        to_send = `CELL_MAX + 1;    // one extra stays waiting at a port
        guard = 0;
        while (o_ready_a || o_ready_b) begin   // until the DUT stops taking flits
            @(negedge clk);
            step(1'b1, 1'b1, 1'b0);
            guard++;
            assert (guard < 200) else die("timeout while filling the buffer");
        end
        alt_on = 1'b0;
        repeat (50) begin
            @(negedge clk);
            step(1'b1, 1'b1, 1'b0);
            assert (!o_ready_a && !o_ready_b) else die("input ready high with the buffer full");
        end
        assert (fill_acc == `CELL_MAX)
            else fail_value("accepted count", 128'(`CELL_MAX + 1), 128'(fill_acc + 1));

        phase = "drain";
        guard = 0;
        while (valid_in[0] || valid_in[1] || exp_id.size() > 0 || o_valid_c) begin
            @(negedge clk);
            step(1'b1, 1'b1, 1'b1);
            guard++;
            assert (guard < 500) else die("timeout while draining the buffer");
        end
        fill_on = 1'b0;

        $display("Regression passed");
        $finish;
    end

endmodule
